// File: flist.f
rtl/ipv4_fib_pkg.sv
rtl/fib_route_table.sv
rtl/fib_bank_match.sv
rtl/fib_lookup.sv
rtl/fib_result_fifo.sv
rtl/ipv4_fib_lut.sv
tb/fib_checker.sv
tb/tb_ipv4_fib_lut.sv

// File: rtl/fib_bank_match.sv
/*
 * Priority match of one destination address over a bank of routes.
 * The lowest matching row of the bank supplies next hop and interface.
 */
`timescale 1ns/1ps
`default_nettype none

module fib_bank_match (
	input wire logic [ipv4_fib_pkg::IPV4_ADDR_W-1:0] i_daddr,
	input ipv4_fib_pkg::fib_route_t [ipv4_fib_pkg::FIB_BANK_ROWS-1:0] i_bank_routes,
	output ipv4_fib_pkg::fib_result_t o_hit
);
	import ipv4_fib_pkg::*;

	logic [FIB_BANK_ROWS-1:0] row_hit;

	// Per-row compare against the stored, already masked network
	always_comb begin
		for (int r = 0; r < FIB_BANK_ROWS; r++) begin
			row_hit[r] = ((i_daddr & i_bank_routes[r].mask) == i_bank_routes[r].net);
		end
	end

	// Walk from the top down so the lowest row is the last one written
	always_comb begin
		o_hit = '0;
		for (int r = FIB_BANK_ROWS - 1; r >= 0; r--) begin
			if (row_hit[r]) begin
				o_hit.found = 1'b1;
				o_hit.oif = i_bank_routes[r].oif;
				o_hit.nh = i_bank_routes[r].nh;
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/fib_lookup.sv
/*
 * Parallel lookup over the whole table, split into banks of rows.
 * The lowest bank with a hit wins, and the result is registered one cycle
 * after the destination address is presented.
 */
`timescale 1ns/1ps
`default_nettype none

module fib_lookup (
	input wire logic Bus2IP_Clk,
	input wire logic reset,
	input wire logic [ipv4_fib_pkg::IPV4_ADDR_W-1:0] i_daddr,
	input wire logic i_daddr_valid,
	input ipv4_fib_pkg::fib_route_array_t i_routes,
	output ipv4_fib_pkg::fib_result_t o_result,
	output logic o_result_valid
);
	import ipv4_fib_pkg::*;

	fib_result_t bank_hit [FIB_BANKS];
	fib_result_t best;

	// --------------------
	// One matcher per bank
	for (genvar b = 0; b < FIB_BANKS; b++) begin : g_bank
		fib_bank_match u_match (
			.i_daddr(i_daddr),
			.i_bank_routes(i_routes[b*FIB_BANK_ROWS +: FIB_BANK_ROWS]),
			.o_hit(bank_hit[b])
		);
	end

	// Bank priority with bank 0 holding the lowest rows
	always_comb begin
		best = '0;
		for (int b = FIB_BANKS - 1; b >= 0; b--) begin
			if (bank_hit[b].found) begin
				best = bank_hit[b];
			end
		end
	end

	// --------------------
	// Result register
	always_ff @(posedge Bus2IP_Clk) begin
		if (reset) begin
			o_result <= '0;
			o_result_valid <= 1'b0;
		end else if (i_daddr_valid) begin
			o_result <= best;
			o_result_valid <= 1'b1;
		end else begin
			// Idle cycles present an all-zero result
			o_result <= '0;
			o_result_valid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: rtl/fib_result_fifo.sv
/*
 * Small first-word-fall-through queue for lookup results.
 * The head word is visible on o_dout whenever o_empty is low.
 */
`timescale 1ns/1ps
`default_nettype none

module fib_result_fifo (
	input wire logic Bus2IP_Clk,
	input wire logic reset,
	input wire logic i_wr_en,
	input ipv4_fib_pkg::fib_queue_t i_din,
	input wire logic i_rd_en,
	output ipv4_fib_pkg::fib_queue_t o_dout,
	output logic o_empty,
	output logic o_full
);
	import ipv4_fib_pkg::*;

	fib_queue_t mem [FIB_FIFO_DEPTH];
	logic [FIB_FIFO_DEPTH_BITS-1:0] wr_ptr;
	logic [FIB_FIFO_DEPTH_BITS-1:0] rd_ptr;
	logic [FIB_FIFO_DEPTH_BITS:0] count;
	logic do_wr;
	logic do_rd;

	assign o_empty = (count == '0);
	assign o_full = (count == FIB_FIFO_DEPTH);

	// Writes when full and reads when empty are dropped
	assign do_wr = i_wr_en & ~o_full;
	assign do_rd = i_rd_en & ~o_empty;

	// Storage
	always_ff @(posedge Bus2IP_Clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= i_din;
		end
	end

	// --------------------
	// Pointers and fill level
	always_ff @(posedge Bus2IP_Clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Head of queue falls through
	assign o_dout = mem[rd_ptr];

endmodule

`default_nettype wire

// File: rtl/fib_route_table.sv
/*
 * Route storage of the forwarding table and its host read/write port.
 * Each host request is served once under a four-phase req/ack handshake.
 * The whole table is exported for the parallel lookup.
 */
`timescale 1ns/1ps
`default_nettype none

module fib_route_table (
	input wire logic Bus2IP_Clk,
	input wire logic reset,
	input wire logic i_rd_req,
	input wire logic [ipv4_fib_pkg::FIB_ROW_BITS-1:0] i_rd_addr,
	input wire logic i_wr_req,
	input wire logic [ipv4_fib_pkg::FIB_ROW_BITS-1:0] i_wr_addr,
	input ipv4_fib_pkg::fib_route_t i_wr_route,
	output logic o_rd_ack,
	output logic o_wr_ack,
	output ipv4_fib_pkg::fib_route_t o_rd_route,
	output ipv4_fib_pkg::fib_route_array_t o_routes
);
	import ipv4_fib_pkg::*;

	typedef enum logic {
		ST_IDLE,
		ST_ACKED
	} hs_state_t;

	hs_state_t state;
	fib_route_array_t routes;
	fib_route_t wr_masked;
	logic [FIB_ROW_BITS-1:0] rd_sel;
	logic hold_rd;
	logic hold_wr;

	// Network is stored masked so the lookup only needs one AND per row
	always_comb begin
		wr_masked = i_wr_route;
		wr_masked.net = i_wr_route.net & i_wr_route.mask;
	end

	// Ack is held only while its own request stays up
	assign hold_rd = o_rd_ack & i_rd_req;
	assign hold_wr = o_wr_ack & i_wr_req;

	// --------------------
	// Handshake and table update
	always_ff @(posedge Bus2IP_Clk) begin
		if (reset) begin
			state <= ST_IDLE;
			o_rd_ack <= 1'b0;
			o_wr_ack <= 1'b0;
			// Every row holds network 0 under a full mask
			for (int i = 0; i < FIB_ROWS; i++) begin
				routes[i] <= '{net: '0, mask: '1, nh: '0, oif: '0};
			end
		end else begin
			case (state)
				ST_IDLE: begin
					if (i_rd_req) begin
						o_rd_ack <= 1'b1;
						state <= ST_ACKED;
					end else if (i_wr_req) begin
						routes[i_wr_addr] <= wr_masked;
						o_wr_ack <= 1'b1;
						state <= ST_ACKED;
					end
				end
				ST_ACKED: begin
					o_rd_ack <= hold_rd;
					o_wr_ack <= hold_wr;
					if (!hold_rd && !hold_wr) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Row index for reads is taken on the accepting edge
	always_ff @(posedge Bus2IP_Clk) begin
		if (state == ST_IDLE && i_rd_req) begin
			rd_sel <= i_rd_addr;
		end
	end

	assign o_rd_route = routes[rd_sel];
	assign o_routes = routes;

endmodule

`default_nettype wire

// File: rtl/ipv4_fib_lut.sv
/*
 * Top level of the IPv4 forwarding table.
 * Connects the route table, the banked lookup and the result FIFO to the
 * host port, the lookup port and the immediate next-hop output.
 */
`timescale 1ns/1ps
`default_nettype none

module ipv4_fib_lut (
	input wire logic Bus2IP_Clk,
	input wire logic reset,

	// Host table access
	input wire logic i_rd_req,
	input wire logic [ipv4_fib_pkg::FIB_ROW_BITS-1:0] i_rd_addr,
	output logic o_rd_ack,
	output ipv4_fib_pkg::fib_route_t o_rd_route,
	input wire logic i_wr_req,
	input wire logic [ipv4_fib_pkg::FIB_ROW_BITS-1:0] i_wr_addr,
	input ipv4_fib_pkg::fib_route_t i_wr_route,
	output logic o_wr_ack,

	// Lookup request
	input wire logic [ipv4_fib_pkg::IPV4_ADDR_W-1:0] i_daddr,
	input wire logic i_daddr_valid,
	output logic o_daddr_ready,

	// Immediate result for the ARP stage
	output logic [ipv4_fib_pkg::IPV4_ADDR_W-1:0] o_im_nh,
	output logic o_im_valid,

	// Queued result
	input wire logic i_rd_from_magic,
	output logic o_found,
	output logic [ipv4_fib_pkg::FIB_OIF_W-1:0] o_oif,
	output logic o_valid
);
	import ipv4_fib_pkg::*;

	fib_route_array_t routes;
	fib_result_t result;
	logic result_valid;
	fib_queue_t q_din;
	fib_queue_t q_dout;
	logic q_empty;
	logic q_full;

	fib_route_table u_table (
		.Bus2IP_Clk(Bus2IP_Clk),
		.reset(reset),
		.i_rd_req(i_rd_req),
		.i_rd_addr(i_rd_addr),
		.i_wr_req(i_wr_req),
		.i_wr_addr(i_wr_addr),
		.i_wr_route(i_wr_route),
		.o_rd_ack(o_rd_ack),
		.o_wr_ack(o_wr_ack),
		.o_rd_route(o_rd_route),
		.o_routes(routes)
	);

	fib_lookup u_lookup (
		.Bus2IP_Clk(Bus2IP_Clk),
		.reset(reset),
		.i_daddr(i_daddr),
		.i_daddr_valid(i_daddr_valid),
		.i_routes(routes),
		.o_result(result),
		.o_result_valid(result_valid)
	);

	// Only found and oif are queued since next hop goes out immediately
	assign q_din.found = result.found;
	assign q_din.oif = result.oif;

	fib_result_fifo u_fifo (
		.Bus2IP_Clk(Bus2IP_Clk),
		.reset(reset),
		.i_wr_en(result_valid),
		.i_din(q_din),
		.i_rd_en(i_rd_from_magic),
		.o_dout(q_dout),
		.o_empty(q_empty),
		.o_full(q_full)
	);

	assign o_im_nh = result.nh;
	assign o_im_valid = result_valid;
	assign o_found = q_dout.found;
	assign o_oif = q_dout.oif;
	assign o_valid = ~q_empty;
	assign o_daddr_ready = ~q_full;

endmodule

`default_nettype wire

// File: rtl/ipv4_fib_pkg.sv
/*
 * Shared widths, table geometry and packed types of the IPv4 forwarding table.
 * Compiled first and imported by every RTL module of the design.
 */
`default_nettype none

package ipv4_fib_pkg;

	// Table geometry
	localparam int FIB_ROWS = 32;
	localparam int FIB_ROW_BITS = 5;
	localparam int FIB_BANK_ROWS = 8;
	localparam int FIB_BANKS = 4;

	// Field widths
	localparam int IPV4_ADDR_W = 32;
	localparam int FIB_OIF_W = 8;

	// Result queue
	localparam int FIB_FIFO_DEPTH_BITS = 2;
	localparam int FIB_FIFO_DEPTH = 1 << FIB_FIFO_DEPTH_BITS;

	// One route with its network kept already masked
	typedef struct packed {
		logic [IPV4_ADDR_W-1:0] net;
		logic [IPV4_ADDR_W-1:0] mask;
		logic [IPV4_ADDR_W-1:0] nh;
		logic [FIB_OIF_W-1:0] oif;
	} fib_route_t;

	// One lookup result
	typedef struct packed {
		logic found;
		logic [FIB_OIF_W-1:0] oif;
		logic [IPV4_ADDR_W-1:0] nh;
	} fib_result_t;

	// Word of the result FIFO
	typedef struct packed {
		logic found;
		logic [FIB_OIF_W-1:0] oif;
	} fib_queue_t;

	// Whole table with row 0 in the low bits
	typedef fib_route_t [FIB_ROWS-1:0] fib_route_array_t;

endpackage

`default_nettype wire

// File: tb/fib_checker.sv
/*
 * Monitor of the forwarding table ports.
 * Holds the expected lookup results and the expected read row, and checks
 * the host ack protocol, the read data, o_im_nh and every FIFO pop.
 */
`timescale 1ns/1ps
`default_nettype none

module fib_checker (
	input wire logic Bus2IP_Clk,
	input wire logic reset,
	input wire logic i_rd_req,
	input wire logic i_wr_req,
	input wire logic i_rd_from_magic,
	input wire logic i_rd_ack,
	input wire logic i_wr_ack,
	input ipv4_fib_pkg::fib_route_t i_rd_route,
	input wire logic i_daddr_ready,
	input wire logic [ipv4_fib_pkg::IPV4_ADDR_W-1:0] i_im_nh,
	input wire logic i_im_valid,
	input wire logic i_found,
	input wire logic [ipv4_fib_pkg::FIB_OIF_W-1:0] i_oif,
	input wire logic i_valid,
	output int o_mismatches,
	output int o_failures
);
	import ipv4_fib_pkg::*;

	fib_result_t exp_im [$];
	fib_queue_t exp_q [$];
	fib_route_t exp_rd;
	logic rd_req_d;
	logic wr_req_d;

	initial begin
		o_mismatches = 0;
		o_failures = 0;
	end

	task automatic report_mismatch(input string name, input logic [127:0] exp,
			input logic [127:0] got);
		$display("mismatch %s: expected %0h got %0h at %0t", name, exp, got, $time);
		o_mismatches++;
	endtask

	task automatic report_failure(input string what);
		$display("error: %s at %0t", what, $time);
		o_failures++;
	endtask

	// --------------------
	// Expectations from the testbench
	task automatic expect_lookup(input fib_result_t res);
		fib_queue_t w;
		w.found = res.found;
		w.oif = res.oif;
		exp_im.push_back(res);
		exp_q.push_back(w);
	endtask

	task automatic expect_read(input fib_route_t route);
		exp_rd = route;
	endtask

	task automatic check_ready(input logic exp);
		if (i_daddr_ready !== exp) begin
			report_mismatch("o_daddr_ready", exp, i_daddr_ready);
		end
	endtask

	task automatic final_check();
		if (exp_im.size() != 0 || exp_q.size() != 0) begin
			report_failure($sformatf("%0d immediate and %0d queued results never came out",
				exp_im.size(), exp_q.size()));
		end
		if (i_valid !== 1'b0) begin
			report_failure("FIFO still shows a result after the last pop");
		end
	endtask

	// Ack rises one cycle after req and falls one cycle after req drops
	task automatic check_ack(input string name, input logic req, input logic req_d,
			input logic ack);
		if (ack && !req_d) begin
			report_failure({name, " ack high although its request was low"});
		end
		if (req_d && req && !ack) begin
			report_failure({name, " ack low although its request was held"});
		end
	endtask

	// --------------------
	// Port monitor
	always @(posedge Bus2IP_Clk) begin
		fib_result_t e;
		fib_queue_t w;
		if (reset) begin
			rd_req_d <= 1'b0;
			wr_req_d <= 1'b0;
		end else begin
			check_ack("read", i_rd_req, rd_req_d, i_rd_ack);
			check_ack("write", i_wr_req, wr_req_d, i_wr_ack);
			if (i_rd_ack && i_rd_route !== exp_rd) begin
				report_mismatch("o_rd_route", exp_rd, i_rd_route);
			end
			if (i_im_valid) begin
				if (exp_im.size() == 0) begin
					report_failure("immediate result without a pending lookup");
				end else begin
					e = exp_im.pop_front();
					if (i_im_nh !== e.nh) begin
						report_mismatch("o_im_nh", e.nh, i_im_nh);
					end
				end
			end
			// Pop of the FIFO head
			if (i_valid && i_rd_from_magic) begin
				if (exp_q.size() == 0) begin
					report_failure("FIFO holds a result that was never expected");
				end else begin
					w = exp_q.pop_front();
					if (i_found !== w.found) begin
						report_mismatch("o_found", w.found, i_found);
					end
					if (i_oif !== w.oif) begin
						report_mismatch("o_oif", w.oif, i_oif);
					end
				end
			end
			rd_req_d <= i_rd_req;
			wr_req_d <= i_wr_req;
		end
	end

endmodule

`default_nettype wire

// File: tb/tb_ipv4_fib_lut.sv
/*
 * Testbench of the IPv4 forwarding table.
 * Drives the host and lookup ports, keeps a shadow table for the expected
 * results and leaves all comparing to the checker instance.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_ipv4_fib_lut;
	import ipv4_fib_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int N_RAND_LOOKUPS = 16;
	localparam int HOST_OPS = 3 * FIB_ROWS + 10;
	localparam int LOOKUPS = N_RAND_LOOKUPS + 12;
	localparam int TIMEOUT_NS = (HOST_OPS * 8 + LOOKUPS * 10 + 50) * CLK_PERIOD;

	logic Bus2IP_Clk;
	logic reset;
	logic i_rd_req;
	logic [FIB_ROW_BITS-1:0] i_rd_addr;
	logic i_wr_req;
	logic [FIB_ROW_BITS-1:0] i_wr_addr;
	fib_route_t i_wr_route;
	logic [IPV4_ADDR_W-1:0] i_daddr;
	logic i_daddr_valid;
	logic i_rd_from_magic;
	logic o_rd_ack;
	logic o_wr_ack;
	fib_route_t o_rd_route;
	logic o_daddr_ready;
	logic [IPV4_ADDR_W-1:0] o_im_nh;
	logic o_im_valid;
	logic o_found;
	logic [FIB_OIF_W-1:0] o_oif;
	logic o_valid;
	int mismatches;
	int failures;
	integer seed;
	fib_route_t shadow [FIB_ROWS];

	ipv4_fib_lut UUT (.*);

	fib_checker u_chk (
		.Bus2IP_Clk(Bus2IP_Clk),
		.reset(reset),
		.i_rd_req(i_rd_req),
		.i_wr_req(i_wr_req),
		.i_rd_from_magic(i_rd_from_magic),
		.i_rd_ack(o_rd_ack),
		.i_wr_ack(o_wr_ack),
		.i_rd_route(o_rd_route),
		.i_daddr_ready(o_daddr_ready),
		.i_im_nh(o_im_nh),
		.i_im_valid(o_im_valid),
		.i_found(o_found),
		.i_oif(o_oif),
		.i_valid(o_valid),
		.o_mismatches(mismatches),
		.o_failures(failures)
	);

	initial begin
		Bus2IP_Clk = 1'b0;
		forever #(CLK_PERIOD / 2) Bus2IP_Clk = ~Bus2IP_Clk;
	end

	// First row whose masked address equals its network wins
	function automatic fib_result_t fib_ref_lookup(input logic [IPV4_ADDR_W-1:0] daddr);
		fib_result_t res;
		res = '0;
		for (int r = 0; r < FIB_ROWS; r++) begin
			if (!res.found && ((daddr & shadow[r].mask) == shadow[r].net)) begin
				res.found = 1'b1;
				res.nh = shadow[r].nh;
				res.oif = shadow[r].oif;
			end
		end
		return res;
	endfunction

	function automatic fib_route_t make_route(input logic [31:0] net, input logic [31:0] mask,
			input logic [31:0] nh, input logic [7:0] oif);
		fib_route_t rt;
		rt.net = net;
		rt.mask = mask;
		rt.nh = nh;
		rt.oif = oif;
		return rt;
	endfunction

	// Random prefix under 192.0.0.0/4 so that 224.0.0.1 never matches
	function automatic fib_route_t rand_route();
		fib_route_t rt;
		int len;
		len = 8 + ({$random(seed)} % 21);
		rt.mask = 32'hFFFF_FFFF << (32 - len);
		rt.net = $random(seed);
		rt.net[31:28] = 4'hC;
		rt.nh = $random(seed);
		rt.oif = $random(seed);
		return rt;
	endfunction

	// --------------------
	// Host port
	task automatic write_row(input int row, input fib_route_t route);
		@(negedge Bus2IP_Clk);
		i_wr_addr = row[FIB_ROW_BITS-1:0];
		i_wr_route = route;
		i_wr_req = 1'b1;
		@(negedge Bus2IP_Clk);
		while (!o_wr_ack) @(negedge Bus2IP_Clk);
		// Request stays up a while so that ack has to stay up with it
		repeat (2) @(negedge Bus2IP_Clk);
		i_wr_req = 1'b0;
		shadow[row] = route;
		shadow[row].net = route.net & route.mask;
		while (o_wr_ack) @(negedge Bus2IP_Clk);
	endtask

	task automatic read_row(input int row);
		u_chk.expect_read(shadow[row]);
		@(negedge Bus2IP_Clk);
		i_rd_addr = row[FIB_ROW_BITS-1:0];
		i_rd_req = 1'b1;
		@(negedge Bus2IP_Clk);
		while (!o_rd_ack) @(negedge Bus2IP_Clk);
		repeat (2) @(negedge Bus2IP_Clk);
		i_rd_req = 1'b0;
		while (o_rd_ack) @(negedge Bus2IP_Clk);
	endtask

	// --------------------
	// Lookup port and result queue
	task automatic present(input logic [IPV4_ADDR_W-1:0] addr);
		@(negedge Bus2IP_Clk);
		i_daddr = addr;
		i_daddr_valid = 1'b1;
		u_chk.expect_lookup(fib_ref_lookup(addr));
	endtask

	task automatic end_lookups();
		@(negedge Bus2IP_Clk);
		i_daddr_valid = 1'b0;
	endtask

	task automatic drain(input int n);
		repeat (n) begin
			while (!o_valid) @(negedge Bus2IP_Clk);
			i_rd_from_magic = 1'b1;
			@(negedge Bus2IP_Clk);
			i_rd_from_magic = 1'b0;
		end
	endtask

	task automatic lookup_one(input logic [IPV4_ADDR_W-1:0] addr);
		present(addr);
		end_lookups();
		drain(1);
	endtask

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
		$display("** FAIL **");
		$finish;
	end

	initial begin
		int r;
		seed = 65737;
		reset = 1'b1;
		i_rd_req = 1'b0;
		i_rd_addr = '0;
		i_wr_req = 1'b0;
		i_wr_addr = '0;
		i_wr_route = '0;
		i_daddr = '0;
		i_daddr_valid = 1'b0;
		i_rd_from_magic = 1'b0;
		for (int i = 0; i < FIB_ROWS; i++) begin
			shadow[i] = make_route(32'h0, 32'hFFFF_FFFF, 32'h0, 8'h0);
		end
		repeat (2) @(posedge Bus2IP_Clk);
		@(negedge Bus2IP_Clk);
		reset = 1'b0;
		u_chk.check_ready(1'b1);

		// Reset contents, then random routes read back
		for (int i = 0; i < FIB_ROWS; i++) read_row(i);
		for (int i = 0; i < FIB_ROWS; i++) write_row(i, rand_route());
		for (int i = 0; i < FIB_ROWS; i++) read_row(i);

		// Overlapping prefixes within bank 0 and across banks 1 to 3
		write_row(3, make_route(32'h0A01_0000, 32'hFFFF_0000, 32'h0A01_0001, 8'h03));
		write_row(5, make_route(32'h0A00_0000, 32'hFF00_0000, 32'h0A00_0001, 8'h05));
		write_row(20, make_route(32'h0A01_0200, 32'hFFFF_FF00, 32'h0A01_0201, 8'h14));
		write_row(9, make_route(32'hAC10_0000, 32'hFFF0_0000, 32'hAC10_0001, 8'h09));
		write_row(30, make_route(32'hAC10_0000, 32'hFFFF_0000, 32'hAC10_00FE, 8'h1E));
		lookup_one(32'h0A01_0203);
		lookup_one(32'h0A09_0909);
		lookup_one(32'hAC10_0505);
		lookup_one(32'hAC14_0001);
		for (int i = 0; i < N_RAND_LOOKUPS; i++) begin
			r = {$random(seed)} % FIB_ROWS;
			if (i % 2 == 0) begin
				lookup_one(shadow[r].net | ($random(seed) & ~shadow[r].mask));
			end else begin
				lookup_one({4'hC, 28'($random(seed))});
			end
		end

		// No matching row
		lookup_one(32'hE000_0001);

		// Four back to back lookups fill the FIFO
		present(32'h0A01_0203);
		present(32'hE000_0001);
		present(32'hAC10_0505);
		present(32'h0A09_0909);
		end_lookups();
		@(negedge Bus2IP_Clk);
		u_chk.check_ready(1'b0);
		drain(4);
		u_chk.check_ready(1'b1);

		// Rewritten row 3 takes effect, then stops matching
		write_row(3, make_route(32'h0A01_0000, 32'hFFFF_0000, 32'h0A01_00FE, 8'h33));
		lookup_one(32'h0A01_0203);
		write_row(3, make_route(32'hC000_0000, 32'hFF00_0000, 32'hC000_0001, 8'h44));
		lookup_one(32'h0A01_0203);

		repeat (4) @(negedge Bus2IP_Clk);
		u_chk.final_check();
		$display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire
